// ==== verilog.f ====
+incdir+hw
hw/eeprom_pkg.sv
hw/i2c_byte_shift.sv
hw/eeprom_wr.sv
hw/eeprom_top.sv
sim/eeprom_model.sv
sim/tb_eeprom_top.sv

// ==== Bender.yml ====
package:
  name: eeprom_24c16

sources:
  - include_dirs:
      - hw
    files:
      - hw/eeprom_pkg.sv
      - hw/i2c_byte_shift.sv
      - hw/eeprom_wr.sv
      - hw/eeprom_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/eeprom_model.sv
      - sim/tb_eeprom_top.sv

// ==== sim/eeprom_input.txt ====
// columns: op addr wdata expect, all hex, op ff ends the list
// op 0 write, 1 read, 2 random write, 3 random read, 4 write with stray strobes
1 123 00 ff
0 123 3c 00
1 123 00 3c
0 0a5 11 00
0 5a5 ee 00
1 0a5 00 11
1 5a5 00 ee
4 210 77 00
1 210 00 77
1 610 00 ff
2 000 00 00
2 000 00 00
3 000 00 00
2 000 00 00
3 000 00 00
ff 000 00 00

// ==== sim/tb_eeprom_top.sv ====
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module tb_eeprom_top
    import eeprom_pkg::*;
();

    localparam int MAX_WORDS = 4 * 64;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wr_data;
    logic                      scl;
    wire                       sda;
    logic                      ack;
    logic [`EEPROM_DATA_W-1:0] rd_data;
    int                        violations;

    logic [15:0]               vec [0:MAX_WORDS-1];
    logic [`EEPROM_DATA_W-1:0] image [0:`EEPROM_DEPTH-1];
    logic                      written [0:`EEPROM_DEPTH-1];
    integer                    seed;
    int                        errors = 0;
    int                        timeouts = 0;
    int                        ack_count = 0;
    int                        txn_count = 0;
    logic                      hung = 1'b0;

    pullup (sda);

    eeprom_top u_dut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .scl(scl), .sda(sda), .ack(ack), .rd_data(rd_data)
    );

    eeprom_model u_model (.scl(scl), .sda(sda), .violations(violations));

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(negedge CLK)
    begin
        if (ack === 1'b1)
            ack_count++;
    end

    // strobe and wait for ack with optional stray strobes while busy
    task automatic run_txn(input logic is_rd, input logic [`EEPROM_ADDR_W-1:0] a,
                           input logic [`EEPROM_DATA_W-1:0] d, input logic stray,
                           input logic [`EEPROM_DATA_W-1:0] exp, input string what);
        int n;
        @(posedge CLK);
        wr      <= !is_rd;
        rd      <= is_rd;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (stray)
        begin
            repeat (8) @(posedge CLK);
            wr      <= 1'b1;
            addr    <= a ^ 11'h400;
            wr_data <= ~d;
            @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b1;
            @(posedge CLK);
            rd <= 1'b0;
        end
        n = 0;
        @(negedge CLK);
        while (ack !== 1'b1 && n < 200)
        begin
            @(negedge CLK);
            n++;
        end
        if (ack !== 1'b1)
        begin
            $display("timeout: no ack within 200 cycles for %s at address %h", what, a);
            timeouts++;
            hung = 1'b1;
        end
        else
        begin
            txn_count++;
            if (is_rd)
            begin
                assert (rd_data === exp)
                else
                begin
                    errors++;
                    $display("FAILED %0t: %s read %h at %h, expected %h",
                             $time, what, rd_data, a, exp);
                end
            end
            repeat (3) @(negedge CLK);
            assert (ack_count == txn_count)
            else
            begin
                errors++;
                $display("FAILED %0t: %0d ack pulses after %0d transactions",
                         $time, ack_count, txn_count);
            end
        end
    endtask

    initial
    begin
        int                        i;
        logic [15:0]               op;
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [`EEPROM_DATA_W-1:0] d;
        logic [`EEPROM_DATA_W-1:0] exp;
        logic                      is_rd;
        seed    = 32'h52f4;
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        for (int k = 0; k < `EEPROM_DEPTH; k++)
        begin
            image[k]   = 8'hff;
            written[k] = 1'b0;
        end
        $readmemh("sim/eeprom_input.txt", vec);

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        assert (ack === 1'b0)
        else
        begin
            errors++;
            $display("FAILED %0t: ack %b in reset", $time, ack);
        end
        assert (scl === 1'b0 && sda === 1'b1)
        else
        begin
            errors++;
            $display("FAILED %0t: scl %b sda %b in reset", $time, scl, sda);
        end
        assert (rd_data === '0)
        else
        begin
            errors++;
            $display("FAILED %0t: rd_data %h in reset", $time, rd_data);
        end
        @(posedge CLK);
        RESET <= 1'b0;
        repeat (2) @(posedge CLK);

        i = 0;
        while (!hung && i < MAX_WORDS && !$isunknown(vec[i]) && vec[i] !== 16'h00ff)
        begin
            op    = vec[i];
            a     = vec[i+1][`EEPROM_ADDR_W-1:0];
            d     = vec[i+2][`EEPROM_DATA_W-1:0];
            exp   = vec[i+3][`EEPROM_DATA_W-1:0];
            is_rd = (eeprom_op_t'(op[0]) == OP_READ);
            if (op[1])
            begin
                a   = 11'($unsigned($random(seed)) % `EEPROM_DEPTH);
                d   = 8'($random(seed));
                exp = image[a];
            end
            run_txn(is_rd, a, d, op[2], exp, $sformatf("input line %0d", i / 4 + 1));
            if (!is_rd)
            begin
                image[a]   = d;
                written[a] = 1'b1;
            end
            i += 4;
        end

        // read back everything written so far
        for (int k = 0; k < `EEPROM_DEPTH && !hung; k++)
        begin
            if (written[k])
                run_txn(1'b1, 11'(k), 8'h00, 1'b0, image[k], "read-back");
        end

        assert (violations == 0)
        else
        begin
            errors++;
            $display("EEPROM model saw %0d protocol violations on the bus", violations);
        end
        $display("errors: %0d checks, %0d timeouts, %0d protocol", errors, timeouts, violations);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== sim/eeprom_model.sv ====
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    output int   violations
);

    logic [`EEPROM_DATA_W-1:0] mem [0:`EEPROM_DEPTH-1];
    logic                      drive_low = 1'b0;
    logic                      scl_q;
    logic                      sda_q;
    logic                      in_frame = 1'b0;
    logic                      send_pend = 1'b0;   // read control acked, data follows
    logic                      sending = 1'b0;
    logic                      ignore = 1'b0;
    int                        bit_cnt = 0;        // 8 and 9 are the ack slot
    int                        byte_idx = 0;
    int                        viol_cnt = 0;
    logic [2:0]                block = '0;
    logic [7:0]                word = '0;
    logic [7:0]                shreg = '0;
    logic [7:0]                out_byte = '0;

    assign sda        = drive_low ? 1'b0 : 1'bz;
    assign violations = viol_cnt;

    initial
    begin
        for (int i = 0; i < `EEPROM_DEPTH; i++)
            mem[i] = 8'hff;
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b0 && sda_q === 1'b1)
        begin
            // start or repeated start, legal only in the first bit slot
            if (in_frame && bit_cnt > 1)
                viol_cnt++;
            in_frame  = 1'b1;
            bit_cnt   = 0;
            byte_idx  = 0;
            send_pend = 1'b0;
            sending   = 1'b0;
            ignore    = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda === 1'b1 && sda_q === 1'b0)
        begin
            if (in_frame && bit_cnt > 1)
                viol_cnt++;     // stop in the middle of a byte
            in_frame = 1'b0;
            bit_cnt  = 0;
        end
        else if (scl === 1'b0 && sda === 1'b0 && sda_q === 1'b1 && !in_frame)
            viol_cnt++;         // bits with no start
        else if (scl === 1'b1 && scl_q === 1'b0 && in_frame)
        begin
            if (bit_cnt < 8)
            begin
                shreg   = {shreg[6:0], sda === 1'b1};
                bit_cnt = bit_cnt + 1;
            end
            else
                bit_cnt = 9;
        end
        else if (scl === 1'b0 && scl_q === 1'b1 && in_frame)
        begin
            if (bit_cnt == 9)
            begin
                bit_cnt   = 0;
                drive_low = send_pend && !out_byte[7];
                sending   = send_pend;
                send_pend = 1'b0;
            end
            else if (sending && bit_cnt < 8)
                drive_low = !out_byte[7 - bit_cnt];
            else if (sending)
            begin
                drive_low = 1'b0;   // master nack slot
                sending   = 1'b0;
                ignore    = 1'b1;
            end
            else if (bit_cnt == 8 && !ignore)
            begin
                drive_low = 1'b1;
                if (byte_idx == 0 && shreg[7:4] != `EEPROM_DEV_CODE)
                begin
                    viol_cnt++;
                    drive_low = 1'b0;
                    ignore    = 1'b1;
                end
                else if (byte_idx == 0)
                begin
                    block = shreg[3:1];
                    if (shreg[0])
                    begin
                        out_byte  = mem[{block, word}];
                        send_pend = 1'b1;
                    end
                end
                else if (byte_idx == 1)
                    word = shreg;
                else
                begin
                    mem[{block, word}] = shreg;
                    ignore = 1'b1;  // single byte writes only
                end
                byte_idx = byte_idx + 1;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== hw/eeprom_top.sv ====
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_top
    import eeprom_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    output logic                      scl,
    inout  wire                       sda,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rd_data
);

    logic                      ctrl_sda_low;
    logic                      shift_sda_low;
    logic                      sda_in;
    logic                      shift_go;
    logic                      shift_done;
    shift_mode_t               shift_mode;
    logic [`EEPROM_DATA_W-1:0] shift_byte;
    logic [`EEPROM_DATA_W-1:0] shift_rx_byte;

    // open drain, pulled up on the board
    assign sda    = (ctrl_sda_low || shift_sda_low) ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_wr u_ctrl (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wr_data(wr_data),
        .sda_in(sda_in), .scl(scl), .sda_low(ctrl_sda_low), .shift_go(shift_go),
        .shift_mode(shift_mode), .shift_byte(shift_byte), .shift_done(shift_done),
        .shift_rx_byte(shift_rx_byte), .ack(ack), .rd_data(rd_data)
    );

    i2c_byte_shift u_shift (
        .CLK(CLK), .RESET(RESET), .scl(scl), .go(shift_go), .mode(shift_mode),
        .tx_byte(shift_byte), .sda_in(sda_in), .sda_low(shift_sda_low),
        .done(shift_done), .rx_byte(shift_rx_byte)
    );

endmodule

// ==== hw/eeprom_wr.sv ====
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_wr
    import eeprom_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wr_data,
    input  logic                      sda_in,
    output logic                      scl,
    output logic                      sda_low,
    output logic                      shift_go,
    output shift_mode_t               shift_mode,
    output logic [`EEPROM_DATA_W-1:0] shift_byte,
    input  logic                      shift_done,
    input  logic [`EEPROM_DATA_W-1:0] shift_rx_byte,
    output logic                      ack,
    output logic [`EEPROM_DATA_W-1:0] rd_data
);

    ctrl_state_t               state;
    eeprom_op_t                op;
    logic                      armed;      // start/stop first half done
    logic [`EEPROM_ADDR_W-1:0] addr_q;
    logic [`EEPROM_DATA_W-1:0] data_q;
    logic                      shift_busy;

    // scl is CLK / 2, toggled on the falling edge
    always_ff @(negedge CLK)
    begin
        if (RESET)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            op       <= OP_WRITE;
            armed    <= 1'b0;
            sda_low  <= 1'b0;
            shift_go <= 1'b0;
            ack      <= 1'b0;
            rd_data  <= '0;
        end
        else
        begin
            shift_go <= 1'b0;
            ack      <= 1'b0;
            case (state)
                IDLE:
                begin
                    sda_low <= 1'b0;
                    if (wr)
                    begin
                        op    <= OP_WRITE;
                        state <= READY;
                    end
                    else if (rd)
                    begin
                        op    <= OP_READ;
                        state <= READY;
                    end
                end
                READY:
                begin
                    armed <= 1'b0;
                    state <= WRITE_START;
                end
                WRITE_START, READ_START:
                begin
                    if (!scl)
                    begin
                        sda_low <= 1'b0;
                        armed   <= sda_in;  // line must be free first
                    end
                    else if (armed)
                    begin
                        sda_low  <= 1'b1;   // sda falls, scl high
                        shift_go <= 1'b1;
                        armed    <= 1'b0;
                        state    <= (state == WRITE_START) ? CTRL_WRITE : CTRL_READ;
                    end
                end
                CTRL_WRITE:
                begin
                    sda_low <= 1'b0;        // shifter owns the line now
                    if (shift_done)
                    begin
                        shift_go <= 1'b1;
                        state    <= ADDR_WRITE;
                    end
                end
                ADDR_WRITE:
                begin
                    if (shift_done)
                    begin
                        armed <= 1'b0;
                        if (op == OP_WRITE)
                        begin
                            shift_go <= 1'b1;
                            state    <= DATA_WRITE;
                        end
                        else
                            state <= READ_START;
                    end
                end
                CTRL_READ:
                begin
                    sda_low <= 1'b0;
                    if (shift_done)
                    begin
                        shift_go <= 1'b1;
                        state    <= DATA_READ;
                    end
                end
                DATA_WRITE, DATA_READ:
                begin
                    if (shift_done)
                    begin
                        armed <= 1'b0;
                        state <= STOP;
                    end
                end
                STOP:
                begin
                    if (!scl)
                    begin
                        sda_low <= 1'b1;
                        armed   <= 1'b1;
                    end
                    else if (armed)
                    begin
                        sda_low <= 1'b0;    // sda rises, scl high
                        armed   <= 1'b0;
                        state   <= ACKN;
                    end
                end
                ACKN:
                begin
                    ack <= 1'b1;
                    if (op == OP_READ)
                        rd_data <= shift_rx_byte;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

    // byte and mode for the go raised on entry to the current state
    always_comb
    begin
        shift_byte = '0;
        shift_mode = SHIFT_IDLE;
        case (state)
            CTRL_WRITE:
            begin
                shift_byte = {`EEPROM_DEV_CODE, addr_q[`EEPROM_ADDR_W-1:8], 1'b0};
                shift_mode = SHIFT_TX;
            end
            ADDR_WRITE:
            begin
                shift_byte = addr_q[7:0];
                shift_mode = SHIFT_TX;
            end
            DATA_WRITE:
            begin
                shift_byte = data_q;
                shift_mode = SHIFT_TX;
            end
            CTRL_READ:
            begin
                shift_byte = {`EEPROM_DEV_CODE, addr_q[`EEPROM_ADDR_W-1:8], 1'b1};
                shift_mode = SHIFT_TX;
            end
            DATA_READ: shift_mode = SHIFT_RX;
            default:   shift_mode = SHIFT_IDLE;
        endcase
    end

    // go seen without done yet
    always_ff @(posedge CLK)
    begin
        if (RESET)
            shift_busy <= 1'b0;
        else if (shift_go)
            shift_busy <= 1'b1;
        else if (shift_done)
            shift_busy <= 1'b0;
    end

    a_ack_pulse: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack high for two cycles");

    a_go_idle: assert property (@(posedge CLK) disable iff (RESET)
        shift_go |-> !shift_busy)
        else $error("byte started while shifter still busy");

endmodule

// ==== hw/i2c_byte_shift.sv ====
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module i2c_byte_shift
    import eeprom_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      scl,
    input  logic                      go,
    input  shift_mode_t               mode,
    input  logic [`EEPROM_DATA_W-1:0] tx_byte,
    input  logic                      sda_in,
    output logic                      sda_low,
    output logic                      done,
    output logic [`EEPROM_DATA_W-1:0] rx_byte
);

    localparam logic [2:0] LAST_BIT = 3'(`EEPROM_DATA_W - 1);

    shift_mode_t               act;
    logic [2:0]                cnt;    // data slot in progress
    logic [`EEPROM_DATA_W-1:0] sr;

    // slots advance on scl low, the ninth slot is always released
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            act     <= SHIFT_IDLE;
            cnt     <= '0;
            sda_low <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (act == SHIFT_IDLE)
            begin
                if (go && !scl)
                begin
                    act     <= mode;
                    cnt     <= '0;
                    sda_low <= (mode == SHIFT_TX) && !tx_byte[`EEPROM_DATA_W-1];  // msb first
                end
            end
            else if (!scl)
            begin
                if (cnt == LAST_BIT)
                begin
                    // ack slot for tx, nack for rx
                    act     <= SHIFT_IDLE;
                    sda_low <= 1'b0;
                    done    <= 1'b1;
                end
                else
                begin
                    cnt     <= cnt + 3'd1;
                    sda_low <= (act == SHIFT_TX) && !sr[`EEPROM_DATA_W-2];
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (act == SHIFT_IDLE && go && !scl)
            sr <= tx_byte;
        else if (act == SHIFT_TX && !scl)
            sr <= {sr[`EEPROM_DATA_W-2:0], 1'b0};
        else if (act == SHIFT_RX && scl)
            sr <= {sr[`EEPROM_DATA_W-2:0], sda_in};  // sample mid high phase
    end

    assign rx_byte = sr;

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("shifter done held for more than one cycle");

    // a change seen now was made one cycle ago, scl must have been low then
    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_low) |-> !$past(scl))
        else $error("shifter moved sda while scl was high");

endmodule

// ==== hw/eeprom_pkg.sv ====
package eeprom_pkg;

    // controller steps, one per transaction phase
    typedef enum logic [3:0] {
        IDLE,
        READY,
        WRITE_START,
        CTRL_WRITE,
        ADDR_WRITE,
        DATA_WRITE,
        READ_START,     // repeated start of a random read
        CTRL_READ,
        DATA_READ,
        STOP,
        ACKN
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SHIFT_IDLE,
        SHIFT_TX,
        SHIFT_RX
    } shift_mode_t;

    typedef enum logic {OP_WRITE, OP_READ} eeprom_op_t;

endpackage

// ==== hw/eeprom_consts.svh ====
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// byte address, 2048 bytes in 8 blocks of 256
`define EEPROM_ADDR_W 11

`define EEPROM_DATA_W 8

// device type code at the head of every control byte
`define EEPROM_DEV_CODE 4'b1010

`define EEPROM_DEPTH 2048

`endif
